// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = regReadTb
FILELIST  = verilog.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: laneLatch.sv
//**********************************************************
// Lane output register.
// Holds one issued instruction and its two operands for a
// cycle and drops the valid bit of an instruction that sits
// under a mispredicted branch.
//**********************************************************

`timescale 1ns/1ps

module laneLatch (
  input  logic                   clk,
  input  logic                   arstN_i,
  input  logic                   valid_i,
  input  regReadPkg::fuOpE       op_i,
  input  regReadPkg::physTagT    dest_i,
  input  regReadPkg::branchMaskT mask_i,
  input  regReadPkg::immT        imm_i,
  input  regReadPkg::dataT       srcAData_i,
  input  regReadPkg::dataT       srcBData_i,
  input  logic                   mispredict_i,
  input  regReadPkg::ckptIdT     mispredictCkpt_i,
  output logic                   valid_o,
  output regReadPkg::fuOpE       op_o,
  output regReadPkg::physTagT    dest_o,
  output regReadPkg::branchMaskT mask_o,
  output regReadPkg::immT        imm_o,
  output regReadPkg::dataT       srcAData_o,
  output regReadPkg::dataT       srcBData_o
);

  logic squash;

  assign squash = mispredict_i && mask_i[mispredictCkpt_i];  // depends on the bad branch.

  //**********************************************************
  // control
  //**********************************************************
  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i && !squash;
    end
  end

  //**********************************************************
  // payload
  //**********************************************************
  always_ff @(posedge clk) begin
    op_o <= op_i;
    dest_o <= dest_i;
    mask_o <= mask_i;
    imm_o <= imm_i;
    srcAData_o <= srcAData_i;
    srcBData_o <= srcBData_i;
  end

endmodule

// File: operandBypass.sv
//**********************************************************
// Operand bypass for one source of one lane.
// A writeback in the same cycle as the read takes the place
// of the register file value when exactly one port hits.
//**********************************************************

`timescale 1ns/1ps

module operandBypass (
  input  regReadPkg::physTagT                            srcTag_i,
  input  regReadPkg::dataT                               rfData_i,
  input  logic                [regReadPkg::NUM_WB-1:0]   wbValid_i,
  input  regReadPkg::physTagT [regReadPkg::NUM_WB-1:0]   wbTag_i,
  input  regReadPkg::dataT    [regReadPkg::NUM_WB-1:0]   wbData_i,
  output regReadPkg::dataT                               operand_o
);

  logic [regReadPkg::NUM_WB-1:0] hit;

  always_comb begin
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      hit[w] = wbValid_i[w] && (wbTag_i[w] == srcTag_i);
    end
  end

  // Several hits on one tag are not trusted, the stored value is used instead.
  always_comb begin
    operand_o = rfData_i;
    if ($onehot(hit)) begin
      for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
        if (hit[w]) begin
          operand_o = wbData_i[w];
        end
      end
    end
  end

endmodule

// File: physRegFile.sv
//**********************************************************
// Physical register file.
// Four combinational read ports, two per issue lane, and
// two write ports fed by writeback. Writes are held off
// while the core recovers from a mispredict.
//**********************************************************

`timescale 1ns/1ps

module physRegFile (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  input  logic                                                recover_i,
  input  regReadPkg::physTagT [2*regReadPkg::NUM_LANES-1:0]   rdTag_i,
  input  logic                [regReadPkg::NUM_WB-1:0]        wrValid_i,
  input  regReadPkg::physTagT [regReadPkg::NUM_WB-1:0]        wrTag_i,
  input  regReadPkg::dataT    [regReadPkg::NUM_WB-1:0]        wrData_i,
  output regReadPkg::dataT    [2*regReadPkg::NUM_LANES-1:0]   rdData_o
);

  regReadPkg::dataT regArray [regReadPkg::NUM_PHYS_REGS];
  logic [regReadPkg::NUM_WB-1:0] wrEn;

  //**********************************************************
  // write side
  //**********************************************************
  always_comb begin
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      wrEn[w] = wrValid_i[w] && !recover_i;   // results of squashed work must not land.
    end
  end

  always_ff @(posedge clk) begin
    for (int w = 0; w < regReadPkg::NUM_WB; w++) begin
      if (wrEn[w]) begin
        regArray[wrTag_i[w]] <= wrData_i[w];
      end
    end
  end

  //**********************************************************
  // read side
  //**********************************************************
  always_comb begin
    for (int r = 0; r < 2 * regReadPkg::NUM_LANES; r++) begin
      rdData_o[r] = regArray[rdTag_i[r]];
    end
  end

  // Renaming hands out each destination tag once, so two writebacks
  // landing on the same register point to a broken free list upstream.
  wrTagUnique : assert property (
    @(posedge clk) disable iff (!arstN_i)
      (wrEn[0] && wrEn[1]) |-> (wrTag_i[0] != wrTag_i[1])
  );

endmodule

// File: readyTable.sv
//**********************************************************
// Physical register ready table.
// One bit per physical register. Unmap clears a bit, a
// wakeup sets it, and reset or an exception brings back
// the pattern of the committed architectural registers.
//**********************************************************

`timescale 1ns/1ps

module readyTable (
  input  logic                                            clk,
  input  logic                                            arstN_i,
  input  logic                                            exception_i,
  input  logic                [regReadPkg::NUM_UNMAP-1:0] unmapValid_i,
  input  regReadPkg::physTagT [regReadPkg::NUM_UNMAP-1:0] unmapTag_i,
  input  logic                [regReadPkg::NUM_WAKE-1:0]  wakeValid_i,
  input  regReadPkg::physTagT [regReadPkg::NUM_WAKE-1:0]  wakeTag_i,
  output logic                [regReadPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  logic [regReadPkg::NUM_PHYS_REGS-1:0] rdyNext;

  //**********************************************************
  // next state
  //**********************************************************
  always_comb begin
    rdyNext = phyRegRdy_o;
    for (int u = 0; u < regReadPkg::NUM_UNMAP; u++) begin
      if (unmapValid_i[u]) begin
        rdyNext[unmapTag_i[u]] = 1'b0;
      end
    end
    // wakeups come last so they override an unmap of the same tag.
    for (int k = 0; k < regReadPkg::NUM_WAKE; k++) begin
      if (wakeValid_i[k]) begin
        rdyNext[wakeTag_i[k]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arstN_i) begin
    if (!arstN_i) begin
      phyRegRdy_o <= regReadPkg::ARCH_RDY;
    end else if (exception_i) begin
      phyRegRdy_o <= regReadPkg::ARCH_RDY;   // speculative mappings are gone.
    end else begin
      phyRegRdy_o <= rdyNext;
    end
  end

  // A freed register cannot also be producing a result, the rename and
  // issue logic upstream would have to disagree about its owner.
  for (genvar u = 0; u < regReadPkg::NUM_UNMAP; u++) begin : gUnmapChk
    for (genvar k = 0; k < regReadPkg::NUM_WAKE; k++) begin : gWakeChk
      noUnmapWake : assert property (
        @(posedge clk) disable iff (!arstN_i)
          !(unmapValid_i[u] && wakeValid_i[k] && (unmapTag_i[u] == wakeTag_i[k]))
      );
    end
  end

endmodule

// File: regReadPkg.sv
//**********************************************************
// Register-read stage shared definitions.
// Sizes of the physical register file, the branch
// checkpoints and the issue and writeback widths, plus the
// operand, tag and mask types and the opcode encoding.
//**********************************************************

package regReadPkg;

  //**********************************************************
  // sizes
  //**********************************************************
  localparam int NUM_PHYS_REGS = 32;
  localparam int PHYS_TAG_W = 5;
  localparam int DATA_W = 32;
  localparam int NUM_ARCH_REGS = 8;      // tags 0 to 7 hold committed state after reset.
  localparam int NUM_CHECKPOINTS = 4;
  localparam int CKPT_ID_W = 2;
  localparam int NUM_LANES = 2;
  localparam int NUM_WB = 2;
  localparam int NUM_UNMAP = 2;
  localparam int NUM_WAKE = 2;
  localparam int IMM_W = 16;

  // ready pattern for the architectural registers.
  localparam logic [NUM_PHYS_REGS-1:0] ARCH_RDY = {
    {(NUM_PHYS_REGS - NUM_ARCH_REGS){1'b0}},
    {NUM_ARCH_REGS{1'b1}}
  };

  //**********************************************************
  // types
  //**********************************************************
  typedef logic [PHYS_TAG_W-1:0] physTagT;
  typedef logic [DATA_W-1:0] dataT;
  typedef logic [NUM_CHECKPOINTS-1:0] branchMaskT;  // one bit per unresolved branch.
  typedef logic [CKPT_ID_W-1:0] ckptIdT;
  typedef logic [IMM_W-1:0] immT;

  // functional unit class of an issued instruction.
  typedef enum logic [2:0] {
    OP_ALU = 3'd0,
    OP_MUL = 3'd1,
    OP_BRANCH = 3'd2,
    OP_LOAD = 3'd3,
    OP_STORE = 3'd4
  } fuOpE;

endpackage

// File: regReadStage.sv
//**********************************************************
// Register-read stage of the out-of-order core.
// Two issue lanes read their sources from the physical
// register file with writeback forwarding, get squashed on
// a verified mispredict and leave through one register.
// The ready table is kept here for the issue queue.
//**********************************************************

`timescale 1ns/1ps

module regReadStage (
  input  logic                                                clk,
  input  logic                                                arstN_i,
  // issue lanes.
  input  logic                   [regReadPkg::NUM_LANES-1:0]  laneValid_i,
  input  regReadPkg::fuOpE       [regReadPkg::NUM_LANES-1:0]  laneOp_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_LANES-1:0]  laneDest_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_LANES-1:0]  laneSrcA_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_LANES-1:0]  laneSrcB_i,
  input  regReadPkg::branchMaskT [regReadPkg::NUM_LANES-1:0]  laneMask_i,
  input  regReadPkg::immT        [regReadPkg::NUM_LANES-1:0]  laneImm_i,
  // writeback, unmap and wakeup.
  input  logic                   [regReadPkg::NUM_WB-1:0]     wbValid_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_WB-1:0]     wbTag_i,
  input  regReadPkg::dataT       [regReadPkg::NUM_WB-1:0]     wbData_i,
  input  logic                   [regReadPkg::NUM_UNMAP-1:0]  unmapValid_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_UNMAP-1:0]  unmapTag_i,
  input  logic                   [regReadPkg::NUM_WAKE-1:0]   wakeValid_i,
  input  regReadPkg::physTagT    [regReadPkg::NUM_WAKE-1:0]   wakeTag_i,
  // branch resolution and recovery.
  input  logic                                                mispredict_i,
  input  regReadPkg::ckptIdT                                  mispredictCkpt_i,
  input  logic                                                recover_i,
  input  logic                                                exception_i,
  // lanes to execute.
  output logic                   [regReadPkg::NUM_LANES-1:0]  laneValid_o,
  output regReadPkg::fuOpE       [regReadPkg::NUM_LANES-1:0]  laneOp_o,
  output regReadPkg::physTagT    [regReadPkg::NUM_LANES-1:0]  laneDest_o,
  output regReadPkg::branchMaskT [regReadPkg::NUM_LANES-1:0]  laneMask_o,
  output regReadPkg::immT        [regReadPkg::NUM_LANES-1:0]  laneImm_o,
  output regReadPkg::dataT       [regReadPkg::NUM_LANES-1:0]  laneSrcAData_o,
  output regReadPkg::dataT       [regReadPkg::NUM_LANES-1:0]  laneSrcBData_o,
  output logic                   [regReadPkg::NUM_PHYS_REGS-1:0] phyRegRdy_o
);

  regReadPkg::physTagT [2*regReadPkg::NUM_LANES-1:0] rdTag;  // even ports source A.
  regReadPkg::dataT    [2*regReadPkg::NUM_LANES-1:0] rfData;
  regReadPkg::dataT    [regReadPkg::NUM_LANES-1:0]   srcAData;
  regReadPkg::dataT    [regReadPkg::NUM_LANES-1:0]   srcBData;

  //**********************************************************
  // operand fetch
  //**********************************************************
  physRegFile uRegFile (
    .clk       (clk),
    .arstN_i   (arstN_i),
    .recover_i (recover_i),
    .rdTag_i   (rdTag),
    .wrValid_i (wbValid_i),
    .wrTag_i   (wbTag_i),
    .wrData_i  (wbData_i),
    .rdData_o  (rfData)
  );

  for (genvar l = 0; l < regReadPkg::NUM_LANES; l++) begin : gLane
    assign rdTag[2*l] = laneSrcA_i[l];
    assign rdTag[2*l+1] = laneSrcB_i[l];

    operandBypass uBypassA (
      .srcTag_i  (laneSrcA_i[l]),
      .rfData_i  (rfData[2*l]),
      .wbValid_i (wbValid_i),
      .wbTag_i   (wbTag_i),
      .wbData_i  (wbData_i),
      .operand_o (srcAData[l])
    );

    operandBypass uBypassB (
      .srcTag_i  (laneSrcB_i[l]),
      .rfData_i  (rfData[2*l+1]),
      .wbValid_i (wbValid_i),
      .wbTag_i   (wbTag_i),
      .wbData_i  (wbData_i),
      .operand_o (srcBData[l])
    );

    laneLatch uLatch (
      .clk              (clk),
      .arstN_i          (arstN_i),
      .valid_i          (laneValid_i[l]),
      .op_i             (laneOp_i[l]),
      .dest_i           (laneDest_i[l]),
      .mask_i           (laneMask_i[l]),
      .imm_i            (laneImm_i[l]),
      .srcAData_i       (srcAData[l]),
      .srcBData_i       (srcBData[l]),
      .mispredict_i     (mispredict_i),
      .mispredictCkpt_i (mispredictCkpt_i),
      .valid_o          (laneValid_o[l]),
      .op_o             (laneOp_o[l]),
      .dest_o           (laneDest_o[l]),
      .mask_o           (laneMask_o[l]),
      .imm_o            (laneImm_o[l]),
      .srcAData_o       (laneSrcAData_o[l]),
      .srcBData_o       (laneSrcBData_o[l])
    );
  end

  //**********************************************************
  // bookkeeping
  //**********************************************************
  readyTable uReadyTable (
    .clk          (clk),
    .arstN_i      (arstN_i),
    .exception_i  (exception_i),
    .unmapValid_i (unmapValid_i),
    .unmapTag_i   (unmapTag_i),
    .wakeValid_i  (wakeValid_i),
    .wakeTag_i    (wakeTag_i),
    .phyRegRdy_o  (phyRegRdy_o)
  );

endmodule

// File: regReadStimulus.txt
# issue lane op dest srcA srcB mask imm | write port tag rnd data | unmap/wake port tag
# mispredict ckpt | recover | exception | cycle | ready vector (all fields hex)
# lane lane valid op dest mask imm aKind aVal bKind bVal (kind 0 literal, 1 register tag)
lane 0 0
lane 1 0
ready 000000ff
write 0 08 0 11112222
write 1 09 1 0
cycle
write 0 0a 0 a5a5a5a5
write 1 0b 0 0b0b0b0b
cycle
write 0 0c 0 c0c0c0c0
issue 0 1 10 08 09 0 1234
issue 1 3 11 0a 0b 2 beef
cycle
lane 0 1 1 10 0 1234 1 08 1 09
lane 1 1 3 11 2 beef 1 0a 1 0b
write 0 0d 1 0
issue 0 0 12 0d 0c 0 0001
cycle
lane 0 1 0 12 0 0001 1 0d 1 0c
lane 1 0
recover
write 0 0a 0 deadbeef
write 1 0a 0 feedface
issue 1 2 13 0a 0b 1 0002
cycle
lane 1 1 2 13 1 0002 1 0a 1 0b
recover
write 0 0b 0 77778888
issue 0 4 14 0b 08 0 0003
cycle
lane 0 1 4 14 0 0003 0 77778888 1 08
issue 0 0 15 0b 0b 0 0004
cycle
lane 0 1 0 15 0 0004 1 0b 1 0b
issue 0 2 16 08 09 4 0005
issue 1 1 17 0a 0c 3 0006
mispredict 2
cycle
lane 0 0
lane 1 1 1 17 3 0006 1 0a 1 0c
unmap 0 03
unmap 1 05
wake 0 10
wake 1 1f
cycle
ready 800100d7
lane 1 0
exception
wake 0 12
cycle
ready 000000ff

// File: regReadTb.sv
//**********************************************************
// Testbench for the register-read stage.
// Reads commands from regReadStimulus.txt, drives the DUT
// after each falling edge and checks lane outputs and the
// ready vector against a shadow copy of the register file.
//**********************************************************

`timescale 1ns/1ps

module regReadTb;

  localparam int EDGE_TIMEOUT = 200;     // polling steps of 1 ns per clock edge.
  localparam int LINE_LIMIT = 1000;

  logic clk;
  logic arstN;
  logic [regReadPkg::NUM_LANES-1:0] laneValid;
  regReadPkg::fuOpE [regReadPkg::NUM_LANES-1:0] laneOp;
  regReadPkg::physTagT [regReadPkg::NUM_LANES-1:0] laneDest, laneSrcA, laneSrcB;
  regReadPkg::branchMaskT [regReadPkg::NUM_LANES-1:0] laneMask;
  regReadPkg::immT [regReadPkg::NUM_LANES-1:0] laneImm;
  logic [regReadPkg::NUM_WB-1:0] wbValid;
  regReadPkg::physTagT [regReadPkg::NUM_WB-1:0] wbTag;
  regReadPkg::dataT [regReadPkg::NUM_WB-1:0] wbData;
  logic [regReadPkg::NUM_UNMAP-1:0] unmapValid;
  regReadPkg::physTagT [regReadPkg::NUM_UNMAP-1:0] unmapTag;
  logic [regReadPkg::NUM_WAKE-1:0] wakeValid;
  regReadPkg::physTagT [regReadPkg::NUM_WAKE-1:0] wakeTag;
  logic mispredict;
  regReadPkg::ckptIdT mispredictCkpt;
  logic recover;
  logic exception;
  logic [regReadPkg::NUM_LANES-1:0] laneValidOut;
  regReadPkg::fuOpE [regReadPkg::NUM_LANES-1:0] laneOpOut;
  regReadPkg::physTagT [regReadPkg::NUM_LANES-1:0] laneDestOut;
  regReadPkg::branchMaskT [regReadPkg::NUM_LANES-1:0] laneMaskOut;
  regReadPkg::immT [regReadPkg::NUM_LANES-1:0] laneImmOut;
  regReadPkg::dataT [regReadPkg::NUM_LANES-1:0] laneSrcADataOut, laneSrcBDataOut;
  logic [regReadPkg::NUM_PHYS_REGS-1:0] phyRegRdy;

  regReadPkg::dataT shadow [regReadPkg::NUM_PHYS_REGS];  // committed register contents.
  logic [31:0] rngState;

  tbClockGen #(.PERIOD_NS(100.0)) uClock (.clk(clk));

  regReadStage UUT (
    .clk(clk), .arstN_i(arstN),
    .laneValid_i(laneValid), .laneOp_i(laneOp), .laneDest_i(laneDest),
    .laneSrcA_i(laneSrcA), .laneSrcB_i(laneSrcB), .laneMask_i(laneMask),
    .laneImm_i(laneImm),
    .wbValid_i(wbValid), .wbTag_i(wbTag), .wbData_i(wbData),
    .unmapValid_i(unmapValid), .unmapTag_i(unmapTag),
    .wakeValid_i(wakeValid), .wakeTag_i(wakeTag),
    .mispredict_i(mispredict), .mispredictCkpt_i(mispredictCkpt),
    .recover_i(recover), .exception_i(exception),
    .laneValid_o(laneValidOut), .laneOp_o(laneOpOut), .laneDest_o(laneDestOut),
    .laneMask_o(laneMaskOut), .laneImm_o(laneImmOut),
    .laneSrcAData_o(laneSrcADataOut), .laneSrcBData_o(laneSrcBDataOut),
    .phyRegRdy_o(phyRegRdy)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic failRun(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping on first failure");
  endtask

  //**********************************************************
  // compare tasks
  //**********************************************************
  task automatic checkData(input string name, input regReadPkg::dataT got,
                           input regReadPkg::dataT exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("operand data mismatch");
    end
  endtask

  task automatic checkTag(input string name, input regReadPkg::physTagT got,
                          input regReadPkg::physTagT exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("tag mismatch");
    end
  endtask

  task automatic checkOp(input string name, input regReadPkg::fuOpE got,
                         input regReadPkg::fuOpE exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("opcode mismatch");
    end
  endtask

  task automatic checkMask(input string name, input regReadPkg::branchMaskT got,
                           input regReadPkg::branchMaskT exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("branch mask mismatch");
    end
  endtask

  task automatic checkImm(input string name, input regReadPkg::immT got,
                          input regReadPkg::immT exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("immediate mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s got %h expected %h", name, got, exp);
      failRun("valid bit mismatch");
    end
  endtask

  task automatic checkRdy(input logic [regReadPkg::NUM_PHYS_REGS-1:0] got,
                          input logic [regReadPkg::NUM_PHYS_REGS-1:0] exp);
    if (got !== exp) begin
      $display("** Error: phyRegRdy_o got %h expected %h", got, exp);
      failRun("ready vector mismatch");
    end
  endtask

  //**********************************************************
  // cycle control
  //**********************************************************
  task automatic clearInputs();
    laneValid = '0;
    wbValid = '0;
    unmapValid = '0;
    wakeValid = '0;
    mispredict = 1'b0;
    recover = 1'b0;
    exception = 1'b0;
  endtask

  // Moves from one falling edge through the rising edge to the next falling edge.
  task automatic nextCycle();
    int steps;
    steps = 0;
    for (int p = 0; p < regReadPkg::NUM_WB; p++) begin
      if (wbValid[p] && !recover && arstN) begin
        shadow[wbTag[p]] = wbData[p];   // writes during recovery do not land.
      end
    end
    while (clk !== 1'b1) begin
      #1;
      steps++;
      if (steps > EDGE_TIMEOUT) failRun("timed out waiting for the rising clock edge");
    end
    steps = 0;
    while (clk !== 1'b0) begin
      #1;
      steps++;
      if (steps > EDGE_TIMEOUT) failRun("timed out waiting for the falling clock edge");
    end
    clearInputs();
  endtask

  function automatic regReadPkg::dataT pickValue(input logic [31:0] kind,
                                                 input logic [31:0] val);
    if (kind == 32'd1) return shadow[val[regReadPkg::PHYS_TAG_W-1:0]];
    return val;
  endfunction

  //**********************************************************
  // stimulus
  //**********************************************************
  initial begin
    int fd;
    int lines;
    int n;
    int l;
    string line;
    string cmd;
    logic [31:0] f [10];

    rngState = 32'h5ab6_3468;
    arstN = 1'b0;
    laneOp = '{default: regReadPkg::OP_ALU};
    laneDest = '0;
    laneSrcA = '0;
    laneSrcB = '0;
    laneMask = '0;
    laneImm = '0;
    wbTag = '0;
    wbData = '0;
    unmapTag = '0;
    wakeTag = '0;
    mispredictCkpt = '0;
    clearInputs();

    nextCycle();
    nextCycle();
    arstN = 1'b1;

    fd = $fopen("regReadStimulus.txt", "r");
    if (fd == 0) failRun("could not open the stimulus file");
    lines = 0;
    while (!$feof(fd)) begin
      lines++;
      if (lines > LINE_LIMIT) failRun("stimulus file is longer than expected");
      line = "";
      n = $fgets(line, fd);
      cmd = "";
      n = $sscanf(line, "%s", cmd);
      if (n < 1 || cmd.substr(0, 0) == "#") continue;
      n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h", cmd,
                  f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
      l = int'(f[0]);
      case (cmd)
        "issue": begin
          laneValid[l] = 1'b1;
          laneOp[l] = regReadPkg::fuOpE'(f[1][2:0]);
          laneDest[l] = f[2][regReadPkg::PHYS_TAG_W-1:0];
          laneSrcA[l] = f[3][regReadPkg::PHYS_TAG_W-1:0];
          laneSrcB[l] = f[4][regReadPkg::PHYS_TAG_W-1:0];
          laneMask[l] = f[5][regReadPkg::NUM_CHECKPOINTS-1:0];
          laneImm[l] = f[6][regReadPkg::IMM_W-1:0];
        end
        "write": begin
          wbValid[l] = 1'b1;
          wbTag[l] = f[1][regReadPkg::PHYS_TAG_W-1:0];
          if (f[2] == 32'd1) begin
            rngState = xorshift(rngState);
            wbData[l] = rngState;
          end else begin
            wbData[l] = f[3];
          end
        end
        "unmap": begin
          unmapValid[l] = 1'b1;
          unmapTag[l] = f[1][regReadPkg::PHYS_TAG_W-1:0];
        end
        "wake": begin
          wakeValid[l] = 1'b1;
          wakeTag[l] = f[1][regReadPkg::PHYS_TAG_W-1:0];
        end
        "mispredict": begin
          mispredict = 1'b1;
          mispredictCkpt = f[0][regReadPkg::CKPT_ID_W-1:0];
        end
        "recover": recover = 1'b1;
        "exception": exception = 1'b1;
        "cycle": nextCycle();
        "ready": checkRdy(phyRegRdy, f[0]);
        "lane": begin
          checkBit("laneValid_o", laneValidOut[l], f[1][0]);
          if (f[1][0]) begin
            checkOp("laneOp_o", laneOpOut[l], regReadPkg::fuOpE'(f[2][2:0]));
            checkTag("laneDest_o", laneDestOut[l], f[3][regReadPkg::PHYS_TAG_W-1:0]);
            checkMask("laneMask_o", laneMaskOut[l], f[4][regReadPkg::NUM_CHECKPOINTS-1:0]);
            checkImm("laneImm_o", laneImmOut[l], f[5][regReadPkg::IMM_W-1:0]);
            checkData("laneSrcAData_o", laneSrcADataOut[l], pickValue(f[6], f[7]));
            checkData("laneSrcBData_o", laneSrcBDataOut[l], pickValue(f[8], f[9]));
          end
        end
        default: failRun({"unknown stimulus command ", cmd});
      endcase
    end
    $fclose(fd);

    $display("sim passed");
    $finish;
  end

endmodule

// File: tbClockGen.sv
//**********************************************************
// Testbench clock source.
// Free-running clock starting low.
//**********************************************************

`timescale 1ns/1ps

module tbClockGen #(
  parameter real PERIOD_NS = 100.0
) (
  output logic clk
);

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2.0) clk = ~clk;
    end
  end

endmodule

// File: verilog.f
regReadPkg.sv
physRegFile.sv
operandBypass.sv
laneLatch.sv
readyTable.sv
regReadStage.sv
tbClockGen.sv
regReadTb.sv
